//--- sim.f
+incdir+tests
verilog/fcvtPkg.sv
verilog/fpUnpack.sv
verilog/fcvt.sv
verilog/fcvtCsr.sv
verilog/fcvtQueue.sv
verilog/fcvtUnit.sv
tests/fcvtTb.sv

//--- tests/fcvtModel.svh
`ifndef FCVT_MODEL_SVH
`define FCVT_MODEL_SVH

// increment decision from the dropped part, rem against half an ulp
function automatic logic roundsAway(input logic sgn, input logic lsb, input logic [127:0] rem,
                                    input logic [127:0] half, input fcvtPkg::frmT rm);
    if (rem == 0) begin
        return 1'b0;   // exact, nothing to round
    end
    case (rm)
        fcvtPkg::RM_RNE: return (rem > half) || ((rem == half) && lsb);
        fcvtPkg::RM_RDN: return sgn;
        fcvtPkg::RM_RUP: return !sgn;
        fcvtPkg::RM_RMM: return rem >= half;
        default:         return 1'b0;   // rtz
    endcase
endfunction

// int -> fp, returns {flags, result}
function automatic logic [68:0] expectToFp(input fcvtPkg::intT src, input fcvtPkg::opT op,
                                           input logic fmt, input fcvtPkg::frmT rm);
    logic [63:0]  v;
    logic         neg;
    logic [127:0] a;
    logic [127:0] q;
    logic [127:0] rem;
    logic [127:0] half;
    int           p;
    int           msb;
    int           sh;
    int           e;
    p = fmt ? 53 : 24;   // significand bits
    if (op[fcvtPkg::OP_LONG]) v = src;
    else if (op[fcvtPkg::OP_UNSIGNED]) v = {32'b0, src[31:0]};
    else v = {{32{src[31]}}, src[31:0]};
    neg = !op[fcvtPkg::OP_UNSIGNED] && v[63];
    a = {64'b0, neg ? -v : v};
    if (a == 0) begin
        return fmt ? {5'b0, 64'b0} : {5'b0, 32'hffff_ffff, 32'b0};
    end
    msb = 0;
    for (int i = 0; i < 64; i++) begin
        if (a[i]) msb = i;
    end
    sh = msb - (p - 1);
    if (sh > 0) begin
        q    = a >> sh;
        rem  = a - (q << sh);
        half = 128'b1 << (sh - 1);
    end else begin
        q    = a << (-sh);   // fits, exact
        rem  = '0;
        half = '0;
    end
    e = msb + (fmt ? 1023 : 127);
    q = q + roundsAway(neg, q[0], rem, half, rm);
    if (q[p]) begin
        q = q >> 1;   // mantissa overflowed into next binade
        e++;
    end
    if (fmt) return {4'b0, rem != 0, neg, 11'(e), q[51:0]};
    return {4'b0, rem != 0, 32'hffff_ffff, neg, 8'(e), q[22:0]};
endfunction

// fp -> int, returns {flags, result}
function automatic logic [68:0] expectToInt(input fcvtPkg::intT src, input fcvtPkg::opT op,
                                            input logic fmt, input fcvtPkg::frmT rm);
    logic         sgn;
    logic         nan;
    logic         ovf;
    logic         pos;
    logic [127:0] man;
    logic [127:0] mag;
    logic [127:0] rem;
    logic [127:0] half;
    logic [127:0] lim;
    logic [63:0]  sv;
    int           ex;
    int           exMax;
    int           p;
    int           e;
    int           sh;
    p = fmt ? 53 : 24;
    if (fmt) begin
        sgn   = src[63];
        ex    = src[62:52];
        man   = src[51:0];
        exMax = 2047;
    end else if (&src[63:32]) begin
        sgn   = src[31];
        ex    = src[30:23];
        man   = src[22:0];
        exMax = 255;
    end else begin
        sgn   = 1'b0;   // bad boxing reads as nan
        ex    = 255;
        man   = 1;
        exMax = 255;
    end
    nan = (ex == exMax) && (man != 0);
    ovf = (ex == exMax);
    if (ex != 0) man = man | (128'b1 << (p - 1));
    e = ((ex == 0) ? 1 : ex) - (fmt ? 1023 : 127) - (p - 1);   // weight of man lsb
    if (e > 64) begin
        ovf = 1'b1;
        e   = 64;
    end
    rem  = '0;
    half = '0;
    if (e >= 0) begin
        mag = man << e;
    end else begin
        sh   = (-e > 120) ? 120 : -e;
        mag  = man >> sh;
        rem  = man - (mag << sh);
        half = 128'b1 << (sh - 1);
    end
    mag = mag + roundsAway(sgn, mag[0], rem, half, rm);
    lim = op[fcvtPkg::OP_LONG] ? (128'b1 << 63) : (128'b1 << 31);
    if (op[fcvtPkg::OP_UNSIGNED]) ovf = ovf | (sgn ? (mag != 0) : (mag >= (lim << 1)));
    else ovf = ovf | (sgn ? (mag > lim) : (mag >= lim));
    if (ovf) begin
        pos = nan || !sgn;
        if (op[fcvtPkg::OP_UNSIGNED]) sv = pos ? 64'hffff_ffff_ffff_ffff : 64'h0;
        else if (op[fcvtPkg::OP_LONG]) sv = pos ? 64'h7fff_ffff_ffff_ffff : 64'h8000_0000_0000_0000;
        else sv = pos ? 64'h0000_0000_7fff_ffff : 64'hffff_ffff_8000_0000;
        return {5'b10000, sv};
    end
    sv = sgn ? -mag[63:0] : mag[63:0];
    if (!op[fcvtPkg::OP_LONG]) sv = {{32{sv[31]}}, sv[31:0]};   // words sign extend
    return {4'b0, rem != 0, sv};
endfunction

`endif

//--- tests/fcvtTb.sv
`default_nettype none

module fcvtTb;

    localparam int NUM_BLK   = 12;
    localparam int BLK_REQ   = 40;
    localparam int TOTAL_REQ = NUM_BLK * BLK_REQ;
    localparam int TIMEOUT   = 40 * TOTAL_REQ;   // cycles

    `include "fcvtModel.svh"

    logic           clk;
    logic           rstN;
    logic           reqValid;
    fcvtPkg::opT    reqOp;
    logic           reqFmt;
    fcvtPkg::frmT   reqFrm;
    fcvtPkg::intT   reqFpSrc;
    fcvtPkg::intT   reqIntSrc;
    logic           reqCredit;
    logic           resValid;
    fcvtPkg::intT   resData;
    fcvtPkg::flagsT resFlags;
    logic           resCredit;
    logic           frmWe;
    fcvtPkg::frmT   frmWdata;
    logic           flagsClr;
    fcvtPkg::frmT   frm;
    fcvtPkg::flagsT fflags;

    logic [68:0]    expQ[$];        // {flags, result} in request order
    int             errCnt = 0;
    int             checkCnt = 0;
    int             cycles = 0;
    int             reqCredits = 0; // producer side
    int             held = 0;       // result credits granted and not yet used
    int             outstanding = 0;
    fcvtPkg::frmT   curFrm = fcvtPkg::RM_RNE;
    fcvtPkg::flagsT accFlags = '0;

    fcvtUnit i_fcvtUnit (
        .clk(clk), .rstN(rstN),
        .reqValid(reqValid), .reqOp(reqOp), .reqFmt(reqFmt), .reqFrm(reqFrm),
        .reqFpSrc(reqFpSrc), .reqIntSrc(reqIntSrc), .reqCredit(reqCredit),
        .resValid(resValid), .resData(resData), .resFlags(resFlags), .resCredit(resCredit),
        .frmWe(frmWe), .frmWdata(frmWdata), .flagsClr(flagsClr),
        .frm(frm), .fflags(fflags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] want);
        checkCnt++;
        if (got !== want) begin
            errCnt++;
            $display("ERR %s got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus generators

    function automatic fcvtPkg::intT randFp(input logic fmt);
        int          kind;
        int          e;
        logic        s;
        logic [51:0] frac;
        kind = $urandom_range(15);
        s    = $urandom_range(1);
        e    = int'($urandom_range(68)) - 3;   // around the integer range edges
        frac = 52'({$urandom, $urandom});
        frac = frac & ~((52'b1 << $urandom_range(52)) - 1);   // exact and tie cases
        case (kind)
            0: begin
                e        = fmt ? 1024 : 128;   // nan
                frac[29] = 1'b1;
            end
            1: begin
                e    = fmt ? 1024 : 128;       // inf
                frac = '0;
            end
            2: e = fmt ? -1023 : -127;         // zero or denormal
            3: if (!fmt) return {$urandom & 32'hfffe_ffff, $urandom};   // unboxed
            default: ;
        endcase
        if (fmt) return {s, 11'(e + 1023), frac};
        return {32'hffff_ffff, s, 8'(e + 127), frac[51:29]};
    endfunction

    function automatic fcvtPkg::intT randInt();
        fcvtPkg::intT v;
        v = {$urandom, $urandom};
        case ($urandom_range(2))
            0: v = $signed(v) >>> $urandom_range(63);        // smaller magnitudes
            1: v = v & ~((64'b1 << $urandom_range(63)) - 1);  // low zeros
            default: ;
        endcase
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // producer helpers

    task automatic sendRandom();
        fcvtPkg::opT  op;
        logic         fmt;
        fcvtPkg::frmT rm;
        fcvtPkg::frmT eff;
        fcvtPkg::intT fpSrc;
        fcvtPkg::intT intSrc;
        op     = 3'($urandom_range(7));
        fmt    = $urandom_range(1);
        rm     = ($urandom_range(5) == 5) ? fcvtPkg::RM_DYN : 3'($urandom_range(4));
        eff    = (rm == fcvtPkg::RM_DYN) ? curFrm : rm;
        fpSrc  = randFp(fmt);
        intSrc = randInt();
        if (op[fcvtPkg::OP_TOINT]) expQ.push_back(expectToInt(fpSrc, op, fmt, eff));
        else expQ.push_back(expectToFp(intSrc, op, fmt, eff));
        outstanding++;
        if (outstanding > fcvtPkg::QUEUE_DEPTH) begin
            errCnt++;
            $display("more requests accepted than the queue has slots at %0t", $time);
        end
        reqCredits--;
        reqValid  = 1'b1;
        reqOp     = op;
        reqFmt    = fmt;
        reqFrm    = rm;
        reqFpSrc  = fpSrc;
        reqIntSrc = intSrc;
        @(posedge clk);
        #1;
        reqValid = 1'b0;
    endtask

    // drain and let fflags take the last result
    task automatic waitIdle();
        while (expQ.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // result monitor sampled mid cycle

    always @(negedge clk) begin : monitor
        logic [68:0] want;
        if (rstN && reqCredit) begin
            reqCredits++;
            if (reqCredits > fcvtPkg::QUEUE_DEPTH) begin
                errCnt++;
                $display("more request credits returned than queue slots at %0t", $time);
            end
        end
        if (rstN && resValid) begin
            if (expQ.size() == 0) begin
                errCnt++;
                $display("result arrived with no request outstanding at %0t", $time);
            end else begin
                if (held == 0) begin
                    errCnt++;
                    $display("result issued without a result credit at %0t", $time);
                end else begin
                    held--;
                end
                want = expQ.pop_front();
                checkVal("resData", resData, want[63:0]);
                checkVal("resFlags", 64'(resFlags), 64'(want[68:64]));
                accFlags = accFlags | want[68:64];   // model flags accrue
                outstanding--;
            end
        end
    end

    // consumer grants credits at random with long stalls now and then
    initial begin : consumer
        int stall;
        stall     = 0;
        resCredit = 1'b0;
        @(posedge rstN);
        forever begin
            @(posedge clk);
            #1;
            resCredit = 1'b0;
            if (stall > 0) begin
                stall--;
            end else if ($urandom_range(49) == 0) begin
                stall = $urandom_range(40, 15);
            end else if (held < 6 && $urandom_range(2) != 0) begin
                resCredit = 1'b1;
                held++;
            end
        end
    end

    initial begin : main
        int blk;
        int r;
        void'($urandom(32'h5601));
        rstN      = 1'b0;
        reqValid  = 1'b0;
        reqOp     = '0;
        reqFmt    = 1'b0;
        reqFrm    = '0;
        reqFpSrc  = '0;
        reqIntSrc = '0;
        frmWe     = 1'b0;
        frmWdata  = '0;
        flagsClr  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstN       = 1'b1;
        reqCredits = fcvtPkg::QUEUE_DEPTH;

        for (blk = 0; blk < NUM_BLK; blk++) begin
            waitIdle();
            checkVal("fflags", 64'(fflags), 64'(accFlags));
            checkVal("frm", 64'(frm), 64'(curFrm));
            // new dyn mode and accrued flags start over
            curFrm   = 3'($urandom_range(4));
            frmWe    = 1'b1;
            frmWdata = curFrm;
            flagsClr = 1'b1;
            @(posedge clk);
            #1;
            frmWe    = 1'b0;
            flagsClr = 1'b0;
            accFlags = '0;
            for (r = 0; r < BLK_REQ; r++) begin
                while (reqCredits == 0) begin
                    @(posedge clk);
                    #1;
                end
                sendRandom();
                if ($urandom_range(3) == 0) begin
                    @(posedge clk);   // occasional gap
                    #1;
                end
            end
        end

        waitIdle();
        checkVal("fflags", 64'(fflags), 64'(accFlags));
        if (reqCredits != fcvtPkg::QUEUE_DEPTH) begin
            errCnt++;
            $display("only %0d request credits back after drain", reqCredits);
        end
        $display("fcvtTb: %0d checks, %0d errors", checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fcvtUnit.sv
`default_nettype none

module fcvtUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           reqValid,
    input  fcvtPkg::opT    reqOp,
    input  logic           reqFmt,
    input  fcvtPkg::frmT   reqFrm,
    input  fcvtPkg::intT   reqFpSrc,
    input  fcvtPkg::intT   reqIntSrc,
    output logic           reqCredit,
    output logic           resValid,
    output fcvtPkg::intT   resData,
    output fcvtPkg::flagsT resFlags,
    input  logic           resCredit,
    input  logic           frmWe,
    input  fcvtPkg::frmT   frmWdata,
    input  logic           flagsClr,
    output fcvtPkg::frmT   frm,
    output fcvtPkg::flagsT fflags
);

    // head of queue
    fcvtPkg::opT    headOp;
    logic           headFmt;
    fcvtPkg::frmT   headFrm;
    fcvtPkg::intT   headFpSrc;
    fcvtPkg::intT   headIntSrc;
    fcvtPkg::frmT   effFrm;       // dyn resolved

    // unpacked source
    logic           xSgn;
    fcvtPkg::expT   xExp;
    fcvtPkg::manT   xMan;
    logic           xZero;
    logic           xNaN;
    logic           xInf;
    logic           xDenorm;
    fcvtPkg::expT   bias;

    // converter out, registered in the queue
    fcvtPkg::intT   cvtRes;
    fcvtPkg::flagsT cvtFlags;

    ////////////////////////////////////////////////////////////

    fcvtQueue i_fcvtQueue (
        .clk(clk), .rstN(rstN),
        .reqValid(reqValid), .reqOp(reqOp), .reqFmt(reqFmt), .reqFrm(reqFrm),
        .reqFpSrc(reqFpSrc), .reqIntSrc(reqIntSrc),
        .resCredit(resCredit), .reqCredit(reqCredit),
        .headOp(headOp), .headFmt(headFmt), .headFrm(headFrm),
        .headFpSrc(headFpSrc), .headIntSrc(headIntSrc),
        .cvtRes(cvtRes), .cvtFlags(cvtFlags),
        .resValid(resValid), .resData(resData), .resFlags(resFlags)
    );

    fpUnpack i_fpUnpack (
        .fpSrc(headFpSrc), .fmt(headFmt),
        .xSgn(xSgn), .xExp(xExp), .xMan(xMan),
        .xZero(xZero), .xNaN(xNaN), .xInf(xInf), .xDenorm(xDenorm),
        .bias(bias)
    );

    fcvt i_fcvt (
        .xSgn(xSgn), .xExp(xExp), .xMan(xMan),
        .xZero(xZero), .xNaN(xNaN), .xInf(xInf), .xDenorm(xDenorm),
        .bias(bias), .intSrc(headIntSrc), .op(headOp), .frm(effFrm), .fmt(headFmt),
        .cvtRes(cvtRes), .cvtFlags(cvtFlags)
    );

    fcvtCsr i_fcvtCsr (
        .clk(clk), .rstN(rstN),
        .frmWe(frmWe), .frmWdata(frmWdata), .flagsClr(flagsClr),
        .resValid(resValid), .resFlags(resFlags), .reqFrm(headFrm),
        .frm(frm), .fflags(fflags), .effFrm(effFrm)
    );

endmodule

`default_nettype wire

//--- verilog/fcvtQueue.sv
`default_nettype none

module fcvtQueue (
    input  logic           clk,
    input  logic           rstN,
    input  logic           reqValid,
    input  fcvtPkg::opT    reqOp,
    input  logic           reqFmt,
    input  fcvtPkg::frmT   reqFrm,
    input  fcvtPkg::intT   reqFpSrc,
    input  fcvtPkg::intT   reqIntSrc,
    input  logic           resCredit,   // consumer grants one per pulse
    output logic           reqCredit,   // one pulse per freed slot
    output fcvtPkg::opT    headOp,
    output logic           headFmt,
    output fcvtPkg::frmT   headFrm,
    output fcvtPkg::intT   headFpSrc,
    output fcvtPkg::intT   headIntSrc,
    input  fcvtPkg::intT   cvtRes,
    input  fcvtPkg::flagsT cvtFlags,
    output logic           resValid,
    output fcvtPkg::intT   resData,
    output fcvtPkg::flagsT resFlags
);

    // request slots
    fcvtPkg::opT  opQ    [fcvtPkg::QUEUE_DEPTH];
    logic         fmtQ   [fcvtPkg::QUEUE_DEPTH];
    fcvtPkg::frmT frmQ   [fcvtPkg::QUEUE_DEPTH];
    fcvtPkg::intT fpQ    [fcvtPkg::QUEUE_DEPTH];
    fcvtPkg::intT intQ   [fcvtPkg::QUEUE_DEPTH];

    logic [fcvtPkg::QUEUE_PTR_W-1:0] wrPtr;
    logic [fcvtPkg::QUEUE_PTR_W-1:0] rdPtr;
    logic [fcvtPkg::QUEUE_PTR_W:0]   count;     // 0..depth
    logic [fcvtPkg::CRED_W-1:0]      credCnt;   // result credits held
    logic                            issue;     // pop head this cycle

    assign issue = (count != '0) && (credCnt != '0);

    ////////////////////////////////////////////////////////////
    // storage, written at the reqValid edge

    always_ff @(posedge clk) begin
        if (reqValid) begin
            opQ[wrPtr]  <= reqOp;
            fmtQ[wrPtr] <= reqFmt;
            frmQ[wrPtr] <= reqFrm;
            fpQ[wrPtr]  <= reqFpSrc;
            intQ[wrPtr] <= reqIntSrc;
        end
    end

    assign headOp     = opQ[rdPtr];
    assign headFmt    = fmtQ[rdPtr];
    assign headFrm    = frmQ[rdPtr];
    assign headFpSrc  = fpQ[rdPtr];
    assign headIntSrc = intQ[rdPtr];

    ////////////////////////////////////////////////////////////
    // pointers, occupancy, credits

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            credCnt   <= '0;
            resValid  <= 1'b0;
            reqCredit <= 1'b0;
        end else begin
            if (reqValid) begin
                wrPtr <= wrPtr + 1'b1;   // depth is a power of two
            end
            if (issue) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + {{fcvtPkg::QUEUE_PTR_W{1'b0}}, reqValid}
                           - {{fcvtPkg::QUEUE_PTR_W{1'b0}}, issue};
            credCnt <= credCnt + {{(fcvtPkg::CRED_W-1){1'b0}}, resCredit}
                               - {{(fcvtPkg::CRED_W-1){1'b0}}, issue};
            resValid  <= issue;
            reqCredit <= issue;   // slot freed along with the result
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (issue) begin
            resData  <= cvtRes;
            resFlags <= cvtFlags;
        end
    end

    // producer must not overrun the slots
    aSlotFree: assert property (@(posedge clk) disable iff (!rstN)
        reqValid && !issue |-> count < fcvtPkg::QUEUE_DEPTH)
        else $error("request queue overflow");

    // consumer must not hand out more credits than the counter holds
    aCredWrap: assert property (@(posedge clk) disable iff (!rstN)
        resCredit && !issue |-> credCnt != '1)
        else $error("result credit counter wrapped");

endmodule

`default_nettype wire

//--- verilog/fcvtCsr.sv
`default_nettype none

module fcvtCsr (
    input  logic           clk,
    input  logic           rstN,
    input  logic           frmWe,
    input  fcvtPkg::frmT   frmWdata,
    input  logic           flagsClr,
    input  logic           resValid,
    input  fcvtPkg::flagsT resFlags,
    input  fcvtPkg::frmT   reqFrm,     // rm field of the head request
    output fcvtPkg::frmT   frm,
    output fcvtPkg::flagsT fflags,
    output fcvtPkg::frmT   effFrm
);

    ////////////////////////////////////////////////////////////
    // dynamic rounding mode

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            frm <= fcvtPkg::RM_RNE;
        end else if (frmWe) begin
            frm <= frmWdata;
        end
    end

    // dyn picks up the register value
    assign effFrm = (reqFrm == fcvtPkg::RM_DYN) ? frm : reqFrm;

    ////////////////////////////////////////////////////////////
    // accrued flags

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fflags <= '0;
        end else if (flagsClr) begin
            fflags <= '0;                  // clear wins over a same cycle result
        end else if (resValid) begin
            fflags <= fflags | resFlags;   // sticky accumulate
        end
    end

    // software may only load one of the five real modes
    aFrmLegal: assert property (@(posedge clk) disable iff (!rstN)
        frmWe |-> (frmWdata <= fcvtPkg::RM_RMM))
        else $error("frm write with reserved code %b", frmWdata);

endmodule

`default_nettype wire

//--- verilog/fcvt.sv
`default_nettype none

module fcvt (
    input  logic           xSgn,
    input  fcvtPkg::expT   xExp,
    input  fcvtPkg::manT   xMan,
    input  logic           xZero,
    input  logic           xNaN,
    input  logic           xInf,
    input  logic           xDenorm,
    input  fcvtPkg::expT   bias,
    input  fcvtPkg::intT   intSrc,
    input  fcvtPkg::opT    op,
    input  fcvtPkg::frmT   frm,      // resolved, never dyn
    input  logic           fmt,      // 1 double, 0 single
    output fcvtPkg::intT   cvtRes,
    output fcvtPkg::flagsT cvtFlags
);

    logic toInt;
    logic isUns;
    logic isLong;

    // int -> fp path
    fcvtPkg::intT intVal;     // source widened to 64
    fcvtPkg::intT absVal;
    fcvtPkg::intT norm;       // leading one at [63]
    fcvtPkg::intT fpRes;
    logic         intNeg;
    logic         absZero;
    logic [5:0]   msb;        // leading one position
    logic [5:0]   lzCnt;
    fcvtPkg::expT expD;
    logic [7:0]   expS;
    logic [62:0]  sumD;       // {exp, frac} + carry from rounding
    logic [30:0]  sumS;

    // fp -> int path
    logic [12:0]  expVal;     // unbiased, two's complement
    logic         eNeg;
    logic         eBig;       // >= 64, out of range for every size
    logic         eMinus1;
    logic [115:0] fpShifted;  // 64 int bits over 52 frac bits
    logic [63:0]  intPart;
    logic         fGuard;
    logic         fSticky;
    logic [64:0]  mag;        // rounded magnitude
    logic         magOvf;
    logic         outRange;
    logic         satPos;
    fcvtPkg::intT intRes;
    fcvtPkg::intT intOut;
    fcvtPkg::intT satVal;

    // shared rounding
    logic rSgn;
    logic rLsb;
    logic rGuard;
    logic rSticky;
    logic roundUp;

    assign toInt  = op[fcvtPkg::OP_TOINT];
    assign isUns  = op[fcvtPkg::OP_UNSIGNED];
    assign isLong = op[fcvtPkg::OP_LONG];

    ////////////////////////////////////////////////////////////
    // int -> fp

    always_comb begin
        if (isLong) begin
            intVal = intSrc;
        end else if (isUns) begin
            intVal = {32'b0, intSrc[31:0]};
        end else begin
            intVal = {{32{intSrc[31]}}, intSrc[31:0]};
        end
    end

    assign intNeg  = ~isUns & intVal[63];
    assign absVal  = intNeg ? -intVal : intVal;
    assign absZero = ~|absVal;

    // leading one search, last hit wins
    always_comb begin
        msb = 6'd0;
        for (int i = 0; i < fcvtPkg::XLEN; i++) begin
            if (absVal[i]) begin
                msb = 6'(i);
            end
        end
    end

    assign lzCnt = 6'd63 - msb;
    assign norm  = absVal << lzCnt;
    assign expD  = {5'b0, msb} + fcvtPkg::BIAS_D;
    assign expS  = {2'b0, msb} + fcvtPkg::BIAS_S[7:0];   // max 190, no overflow

    // mantissa carry ripples into exponent
    assign sumD = {expD, norm[62:11]} + {62'b0, roundUp};
    assign sumS = {expS, norm[62:40]} + {30'b0, roundUp};

    assign fpRes = fmt ? {intNeg, absZero ? 63'b0 : sumD}
                       : {32'hffff_ffff, intNeg, absZero ? 31'b0 : sumS};   // nan boxed

    ////////////////////////////////////////////////////////////
    // fp -> int

    assign expVal  = {2'b00, xExp} - {2'b00, bias} + {12'b0, xDenorm};
    assign eNeg    = expVal[12];
    assign eBig    = ~eNeg & |expVal[11:6];
    assign eMinus1 = &expVal;

    assign fpShifted = {63'b0, xMan} << expVal[5:0];

    always_comb begin
        if (eNeg) begin
            // |x| < 1, only guard/sticky survive
            intPart = 64'b0;
            fGuard  = eMinus1 & xMan[52];
            fSticky = eMinus1 ? |xMan[51:0] : ~xZero;
        end else begin
            intPart = fpShifted[115:52];
            fGuard  = fpShifted[51];
            fSticky = |fpShifted[50:0];
        end
    end

    assign mag = {1'b0, intPart} + {64'b0, roundUp};

    // range after rounding
    always_comb begin
        if (isUns) begin
            magOvf = xSgn ? |mag : (isLong ? mag[64] : |mag[64:32]);   // -0.x -> 0 is legal
        end else if (xSgn) begin
            magOvf = isLong ? (mag[64] | (mag[63] & |mag[62:0]))
                            : (|mag[64:32] | (mag[31] & |mag[30:0]));
        end else begin
            magOvf = isLong ? |mag[64:63] : |mag[64:31];
        end
    end

    assign outRange = xNaN | xInf | eBig | magOvf;
    assign satPos   = xNaN | ~xSgn;   // nan goes to max

    always_comb begin
        if (isUns) begin
            satVal = satPos ? 64'hffff_ffff_ffff_ffff : 64'h0;
        end else if (isLong) begin
            satVal = satPos ? 64'h7fff_ffff_ffff_ffff : 64'h8000_0000_0000_0000;
        end else begin
            satVal = satPos ? 64'h0000_0000_7fff_ffff : 64'hffff_ffff_8000_0000;
        end
    end

    assign intRes = xSgn ? -mag[63:0] : mag[63:0];
    assign intOut = isLong ? intRes : {{32{intRes[31]}}, intRes[31:0]};   // words sign extend

    ////////////////////////////////////////////////////////////
    // rounding, shared by both directions

    assign rSgn    = toInt ? xSgn : intNeg;
    assign rLsb    = toInt ? intPart[0] : (fmt ? norm[11] : norm[40]);
    assign rGuard  = toInt ? fGuard : (fmt ? norm[10] : norm[39]);
    assign rSticky = toInt ? fSticky : (fmt ? |norm[9:0] : |norm[38:0]);

    always_comb begin
        case (frm)
            fcvtPkg::RM_RNE: roundUp = rGuard & (rSticky | rLsb);
            fcvtPkg::RM_RTZ: roundUp = 1'b0;
            fcvtPkg::RM_RDN: roundUp = rSgn & (rGuard | rSticky);
            fcvtPkg::RM_RUP: roundUp = ~rSgn & (rGuard | rSticky);
            fcvtPkg::RM_RMM: roundUp = rGuard;
            default:         roundUp = 1'b0;   // reserved codes truncate
        endcase
    end

    // result and flags
    assign cvtRes = toInt ? (outRange ? satVal : intOut) : fpRes;

    always_comb begin
        cvtFlags = '0;
        if (toInt) begin
            cvtFlags[fcvtPkg::FLG_NV] = outRange;
            cvtFlags[fcvtPkg::FLG_NX] = ~outRange & (rGuard | rSticky);   // in range only
        end else begin
            cvtFlags[fcvtPkg::FLG_NX] = rGuard | rSticky;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fpUnpack.sv
`default_nettype none

module fpUnpack (
    input  fcvtPkg::intT fpSrc,    // raw fp register contents
    input  logic         fmt,      // 1 double, 0 single
    output logic         xSgn,
    output fcvtPkg::expT xExp,     // biased, single zero extended
    output fcvtPkg::manT xMan,     // hidden bit at [52]
    output logic         xZero,
    output logic         xNaN,
    output logic         xInf,
    output logic         xDenorm,
    output fcvtPkg::expT bias
);

    logic        boxed;     // upper word all ones
    logic [51:0] fracRaw;   // fraction, single left aligned
    logic        expMax;
    logic        expZero;
    logic        fracZero;

    assign boxed = &fpSrc[63:32];

    // field split per format
    always_comb begin
        if (fmt) begin
            xSgn    = fpSrc[63];
            xExp    = fpSrc[62:52];
            fracRaw = fpSrc[51:0];
        end else if (boxed) begin
            xSgn    = fpSrc[31];
            xExp    = {3'b000, fpSrc[30:23]};
            fracRaw = {fpSrc[22:0], 29'b0};
        end else begin
            // broken boxing reads as canonical nan 7fc00000
            xSgn    = 1'b0;
            xExp    = 11'h0ff;
            fracRaw = {1'b1, 51'b0};   // quiet bit only
        end
    end

    assign expMax   = fmt ? &xExp : &xExp[7:0];
    assign expZero  = ~|xExp;
    assign fracZero = ~|fracRaw;

    // classes
    assign xZero   = expZero & fracZero;
    assign xDenorm = expZero & ~fracZero;
    assign xInf    = expMax & fracZero;
    assign xNaN    = expMax & ~fracZero;

    assign xMan = {~expZero, fracRaw};   // no hidden one for denorm/zero
    assign bias = fmt ? fcvtPkg::BIAS_D : fcvtPkg::BIAS_S;

endmodule

`default_nettype wire

//--- verilog/fcvtPkg.sv
`default_nettype none

package fcvtPkg;

    ////////////////////////////////////////////////////////////
    // operand widths

    localparam int XLEN = 64;       // integer register width

    typedef logic [XLEN-1:0] intT;  // int operand, raw fp source, result
    typedef logic [10:0]     expT;  // biased exponent, double sized
    typedef logic [52:0]     manT;  // mantissa incl hidden bit

    // op code {long, unsigned, toInt}
    typedef logic [2:0] opT;
    localparam int OP_TOINT    = 0; // 1 = fp -> int
    localparam int OP_UNSIGNED = 1; // wu / lu forms
    localparam int OP_LONG     = 2; // 64 bit integer side

    ////////////////////////////////////////////////////////////
    // rounding modes

    typedef logic [2:0] frmT;
    localparam frmT RM_RNE = 3'b000; // nearest, ties to even
    localparam frmT RM_RTZ = 3'b001; // toward zero
    localparam frmT RM_RDN = 3'b010; // toward -inf
    localparam frmT RM_RUP = 3'b011; // toward +inf
    localparam frmT RM_RMM = 3'b100; // nearest, ties away
    localparam frmT RM_DYN = 3'b111; // mode comes from frm register

    // flags {nv, dz, of, uf, nx}
    typedef logic [4:0] flagsT;
    localparam int FLG_NV = 4;
    localparam int FLG_NX = 0;

    // exponent biases
    localparam expT BIAS_S = 11'd127;
    localparam expT BIAS_D = 11'd1023;

    ////////////////////////////////////////////////////////////
    // request queue

    localparam int QUEUE_DEPTH = 4; // slots = credits given upstream
    localparam int QUEUE_PTR_W = 2;
    localparam int CRED_W      = 8; // result credit counter width

endpackage

`default_nettype wire
